// ==== hw/rv_dec_config.svh ====
/*
  Build-time constants of the decode unit.
  The read map needs 2*RV_DEC_LANES + 1 word addresses, so with a 4-bit
  address at most 7 lanes fit below the status word.
*/

`ifndef RV_DEC_CONFIG_SVH
`define RV_DEC_CONFIG_SVH

// number of decode lanes
`define RV_DEC_LANES 4

// Wishbone word address and data widths
`define RV_DEC_ADR_W 4
`define RV_DEC_DAT_W 32

// read address of the status word
`define RV_DEC_STATUS_ADR 15

`endif

// ==== hw/rv_dec_pkg.sv ====
/*
  Types shared by the decoder and its testbench.
  Only the RV32I base set is covered, so operation codes stop at 40.
  The operation order below fixes the codes read back over the bus.
*/

package rv_dec_pkg;

  // one instruction word, seen through three format layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } rv_instr_u;

  typedef enum logic [5:0] {
    OP_ILLEGAL = 6'd0,
    OP_LUI = 6'd1,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_FENCE,
    OP_ECALL,
    OP_EBREAK
  } rv_op_e;

  // immediate layout selected per operation
  typedef enum logic [3:0] {
    IMM_NONE = 4'd0,
    IMM_I    = 4'd1,
    IMM_S    = 4'd2,
    IMM_B    = 4'd3,
    IMM_U    = 4'd4,
    IMM_J    = 4'd5,
    IMM_SH   = 4'd6
  } rv_imm_fmt_e;

endpackage

// ==== hw/rv_instr_latch.sv ====
/*
  Write side of the Wishbone classic slave.
  Every write is acknowledged one cycle after it is seen; only addresses
  below RV_DEC_LANES store a word and pulse the matching load bit.
  Reads are left to the result bank.
*/

`timescale 1ns/1ps

`include "rv_dec_config.svh"

module rv_instr_latch
  import rv_dec_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`RV_DEC_ADR_W-1:0]   wb_adr_i,
  input  logic [`RV_DEC_DAT_W-1:0]   wb_dat_i,
  output logic                       wb_ack_o,
  output rv_instr_u                  instr_o [`RV_DEC_LANES],
  output logic [`RV_DEC_LANES-1:0]   load_o
);

  localparam int LANES = `RV_DEC_LANES;
  localparam int ADR_W = `RV_DEC_ADR_W;

  logic             ack_q;
  logic             wr_req;
  logic [LANES-1:0] lane_sel;

  // the ack cycle does not count as a new request
  assign wr_req = wb_cyc_i & wb_stb_i & wb_we_i & ~ack_q;

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_sel[k] = wr_req && (wb_adr_i == ADR_W'(k));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      load_o <= '0;
    end else begin
      ack_q  <= wr_req;
      load_o <= lane_sel;
    end
  end

  // lane slots
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < LANES; k++) begin
      if (lane_sel[k]) begin
        instr_o[k] <= wb_dat_i;
      end
    end
  end

  assign wb_ack_o = ack_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wb_ack_o) |-> wb_cyc_i);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(load_o));

endmodule

// ==== hw/rv_decode_lane.sv ====
/*
  Single-stage RV32I decoder for one lane.
  The result registers load on load_i and done_o follows one cycle later.
  Words outside the 40 base operations decode as illegal with all
  fields and the immediate forced to zero.
*/

`timescale 1ns/1ps

`include "rv_dec_config.svh"

module rv_decode_lane
  import rv_dec_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     load_i,
  input  rv_instr_u                instr_i,
  output logic [`RV_DEC_DAT_W-1:0] ctrl_o,
  output logic [`RV_DEC_DAT_W-1:0] imm_o,
  output logic                     done_o
);

  ////////////////////////////////////////////////////////////////////////////
  // pattern table
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_OPS = 40;

  // {rd used, rs1 used, rs2 used, immediate format}
  localparam logic [6:0] A_N  = {3'b000, IMM_NONE};
  localparam logic [6:0] A_R  = {3'b111, IMM_NONE};
  localparam logic [6:0] A_I  = {3'b110, IMM_I};
  localparam logic [6:0] A_SH = {3'b110, IMM_SH};
  localparam logic [6:0] A_S  = {3'b011, IMM_S};
  localparam logic [6:0] A_B  = {3'b011, IMM_B};
  localparam logic [6:0] A_U  = {3'b100, IMM_U};
  localparam logic [6:0] A_J  = {3'b100, IMM_J};

  // {attributes, mask, match}, one entry per operation code
  localparam logic [70:0] PAT [1:NUM_OPS] = '{
    {A_U,  32'h0000007F, 32'h00000037}, {A_U,  32'h0000007F, 32'h00000017},
    {A_J,  32'h0000007F, 32'h0000006F}, {A_I,  32'h0000707F, 32'h00000067},
    {A_B,  32'h0000707F, 32'h00000063}, {A_B,  32'h0000707F, 32'h00001063},
    {A_B,  32'h0000707F, 32'h00004063}, {A_B,  32'h0000707F, 32'h00005063},
    {A_B,  32'h0000707F, 32'h00006063}, {A_B,  32'h0000707F, 32'h00007063},
    {A_I,  32'h0000707F, 32'h00000003}, {A_I,  32'h0000707F, 32'h00001003},
    {A_I,  32'h0000707F, 32'h00002003}, {A_I,  32'h0000707F, 32'h00004003},
    {A_I,  32'h0000707F, 32'h00005003}, {A_S,  32'h0000707F, 32'h00000023},
    {A_S,  32'h0000707F, 32'h00001023}, {A_S,  32'h0000707F, 32'h00002023},
    {A_I,  32'h0000707F, 32'h00000013}, {A_I,  32'h0000707F, 32'h00002013},
    {A_I,  32'h0000707F, 32'h00003013}, {A_I,  32'h0000707F, 32'h00004013},
    {A_I,  32'h0000707F, 32'h00006013}, {A_I,  32'h0000707F, 32'h00007013},
    {A_SH, 32'hFE00707F, 32'h00001013}, {A_SH, 32'hFE00707F, 32'h00005013},
    {A_SH, 32'hFE00707F, 32'h40005013}, {A_R,  32'hFE00707F, 32'h00000033},
    {A_R,  32'hFE00707F, 32'h40000033}, {A_R,  32'hFE00707F, 32'h00001033},
    {A_R,  32'hFE00707F, 32'h00002033}, {A_R,  32'hFE00707F, 32'h00003033},
    {A_R,  32'hFE00707F, 32'h00004033}, {A_R,  32'hFE00707F, 32'h00005033},
    {A_R,  32'hFE00707F, 32'h40005033}, {A_R,  32'hFE00707F, 32'h00006033},
    {A_R,  32'hFE00707F, 32'h00007033}, {A_N,  32'h0000707F, 32'h0000000F},
    {A_N,  32'hFFFFFFFF, 32'h00000073}, {A_N,  32'hFFFFFFFF, 32'h00100073}
  };

  rv_op_e      op;
  logic [6:0]  attr;
  rv_imm_fmt_e fmt;
  logic [4:0]  rd_f;
  logic [4:0]  rs1_f;
  logic [4:0]  rs2_f;
  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic [31:0] b_imm;
  logic [31:0] u_imm;
  logic [31:0] j_imm;
  logic [31:0] sh_imm;
  logic [31:0] imm_d;
  logic [31:0] ctrl_d;

  // patterns never overlap, at most one entry hits
  always_comb begin
    op   = OP_ILLEGAL;
    attr = '0;
    for (int i = 1; i <= NUM_OPS; i++) begin
      if ((instr_i & PAT[i][63:32]) == PAT[i][31:0]) begin
        op   = rv_op_e'(6'(i));
        attr = PAT[i][70:64];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////////////////////////////////////////

  assign fmt   = rv_imm_fmt_e'(attr[3:0]);
  assign rd_f  = attr[6] ? instr_i.r.rd : 5'd0;
  assign rs1_f = attr[5] ? instr_i.r.rs1 : 5'd0;
  assign rs2_f = attr[4] ? instr_i.r.rs2 : 5'd0;

  assign i_imm  = {{20{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rs2};
  assign s_imm  = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign b_imm  = {{19{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                   instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
  assign u_imm  = {instr_i.u.imm, 12'd0};
  // J bits sit scrambled inside the upper 20
  assign j_imm  = {{12{instr_i.u.imm[19]}}, instr_i.u.imm[7:0], instr_i.u.imm[8],
                   instr_i.u.imm[18:9], 1'b0};
  assign sh_imm = {27'd0, instr_i.r.rs2};

  always_comb begin
    case (fmt)
      IMM_I:   imm_d = i_imm;
      IMM_S:   imm_d = s_imm;
      IMM_B:   imm_d = b_imm;
      IMM_U:   imm_d = u_imm;
      IMM_J:   imm_d = j_imm;
      IMM_SH:  imm_d = sh_imm;
      default: imm_d = '0;
    endcase
  end

  assign ctrl_d = {(op == OP_ILLEGAL), 3'b000, fmt, attr[4], attr[5], attr[6],
                   rs2_f, rs1_f, rd_f, op};

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      ctrl_o <= ctrl_d;
      imm_o  <= imm_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= load_i;
    end
  end

  // an unmatched word leaves nothing but the illegal bit behind
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_i && (op == OP_ILLEGAL) |=> done_o && (ctrl_o == 32'h8000_0000) && (imm_o == '0));

endmodule

// ==== hw/rv_result_bank.sv ====
/*
  Read side of the Wishbone classic slave.
  Holds the last result of every lane plus one status bit per lane.
  Read data is registered with the ack, so a status bit set on the same
  edge shows up only on the next read.
*/

`timescale 1ns/1ps

`include "rv_dec_config.svh"

module rv_result_bank (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RV_DEC_ADR_W-1:0] wb_adr_i,
  input  logic [`RV_DEC_LANES-1:0] load_i,
  input  logic [`RV_DEC_LANES-1:0] done_i,
  input  logic [`RV_DEC_DAT_W-1:0] lane_ctrl_i [`RV_DEC_LANES],
  input  logic [`RV_DEC_DAT_W-1:0] lane_imm_i [`RV_DEC_LANES],
  output logic                     wb_ack_o,
  output logic [`RV_DEC_DAT_W-1:0] wb_dat_o
);

  localparam int LANES = `RV_DEC_LANES;
  localparam int ADR_W = `RV_DEC_ADR_W;
  localparam int DAT_W = `RV_DEC_DAT_W;

  logic [DAT_W-1:0] ctrl_q [LANES];
  logic [DAT_W-1:0] imm_q [LANES];
  logic [LANES-1:0] status_q;
  logic             ack_q;
  logic             rd_req;
  logic [DAT_W-1:0] rd_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
      for (int k = 0; k < LANES; k++) begin
        ctrl_q[k] <= '0;
        imm_q[k]  <= '0;
      end
    end else begin
      for (int k = 0; k < LANES; k++) begin
        if (done_i[k]) begin
          ctrl_q[k] <= lane_ctrl_i[k];
          imm_q[k]  <= lane_imm_i[k];
        end
        // a fresh write wins over an older result
        if (load_i[k]) begin
          status_q[k] <= 1'b0;
        end else if (done_i[k]) begin
          status_q[k] <= 1'b1;
        end
      end
    end
  end

  // address decode
  always_comb begin
    rd_data = '0;
    for (int k = 0; k < LANES; k++) begin
      if (wb_adr_i == ADR_W'(2 * k)) begin
        rd_data = ctrl_q[k];
      end
      if (wb_adr_i == ADR_W'(2 * k + 1)) begin
        rd_data = imm_q[k];
      end
    end
    if (wb_adr_i == ADR_W'(`RV_DEC_STATUS_ADR)) begin
      rd_data = {{(DAT_W - LANES){1'b0}}, status_q};
    end
  end

  assign rd_req = wb_cyc_i & wb_stb_i & ~wb_we_i & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      wb_dat_o <= rd_data;
    end
  end

  assign wb_ack_o = ack_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== hw/rv_decode_unit.sv ====
/*
  Four-lane RV32I decoder behind a Wishbone classic slave.
  No err or retry; the master must hold cyc and stb until ack.
  Results are readable two cycles after the write's ack.
*/

`timescale 1ns/1ps

`include "rv_dec_config.svh"

module rv_decode_unit
  import rv_dec_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`RV_DEC_ADR_W-1:0] wb_adr_i,
  input  logic [`RV_DEC_DAT_W-1:0] wb_dat_i,
  output logic [`RV_DEC_DAT_W-1:0] wb_dat_o,
  output logic                     wb_ack_o
);

  rv_instr_u                 instr [`RV_DEC_LANES];
  logic [`RV_DEC_LANES-1:0]  load;
  logic [`RV_DEC_LANES-1:0]  done;
  logic [`RV_DEC_DAT_W-1:0]  lane_ctrl [`RV_DEC_LANES];
  logic [`RV_DEC_DAT_W-1:0]  lane_imm [`RV_DEC_LANES];
  logic                      wr_ack;
  logic                      rd_ack;

  rv_instr_latch u_latch (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_o (wr_ack),
    .instr_o  (instr),
    .load_o   (load)
  );

  for (genvar k = 0; k < `RV_DEC_LANES; k++) begin : g_lane
    rv_decode_lane u_lane (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .load_i  (load[k]),
      .instr_i (instr[k]),
      .ctrl_o  (lane_ctrl[k]),
      .imm_o   (lane_imm[k]),
      .done_o  (done[k])
    );
  end

  rv_result_bank u_bank (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .load_i      (load),
    .done_i      (done),
    .lane_ctrl_i (lane_ctrl),
    .lane_imm_i  (lane_imm),
    .wb_ack_o    (rd_ack),
    .wb_dat_o    (wb_dat_o)
  );

  // writes and reads never ack together
  assign wb_ack_o = wr_ack | rd_ack;

endmodule

// ==== bench/rv_dec_model.svh ====
/*
  Reference RV32I decoder and word generator for the decode unit testbench.
  Meant to be included inside the testbench module, it calls rand_word there.
  Only the 40 base operations are known; anything else counts as illegal.
*/

`ifndef RV_DEC_MODEL_SVH
`define RV_DEC_MODEL_SVH

// expected control and immediate words for one instruction word
function automatic void expected_decode(input logic [31:0] w, output logic [31:0] ctrl,
                                        output logic [31:0] imm);
  rv_op_e      op;
  rv_imm_fmt_e fmt;
  logic        rd_u;
  logic        rs1_u;
  logic        rs2_u;
  logic [2:0]  f3;
  logic [6:0]  f7;
  op    = OP_ILLEGAL;
  fmt   = IMM_NONE;
  rd_u  = 1'b0;
  rs1_u = 1'b0;
  rs2_u = 1'b0;
  f3    = w[14:12];
  f7    = w[31:25];
  case (w[6:0])
    7'h37: begin
      op   = OP_LUI;
      fmt  = IMM_U;
      rd_u = 1'b1;
    end
    7'h17: begin
      op   = OP_AUIPC;
      fmt  = IMM_U;
      rd_u = 1'b1;
    end
    7'h6f: begin
      op   = OP_JAL;
      fmt  = IMM_J;
      rd_u = 1'b1;
    end
    7'h67: begin
      if (f3 == 3'd0) op = OP_JALR;
      fmt   = IMM_I;
      rd_u  = 1'b1;
      rs1_u = 1'b1;
    end
    7'h63: begin
      case (f3)
        3'd0: op = OP_BEQ;
        3'd1: op = OP_BNE;
        3'd4: op = OP_BLT;
        3'd5: op = OP_BGE;
        3'd6: op = OP_BLTU;
        3'd7: op = OP_BGEU;
        default: op = OP_ILLEGAL;
      endcase
      fmt   = IMM_B;
      rs1_u = 1'b1;
      rs2_u = 1'b1;
    end
    7'h03: begin
      case (f3)
        3'd0: op = OP_LB;
        3'd1: op = OP_LH;
        3'd2: op = OP_LW;
        3'd4: op = OP_LBU;
        3'd5: op = OP_LHU;
        default: op = OP_ILLEGAL;
      endcase
      fmt   = IMM_I;
      rd_u  = 1'b1;
      rs1_u = 1'b1;
    end
    7'h23: begin
      case (f3)
        3'd0: op = OP_SB;
        3'd1: op = OP_SH;
        3'd2: op = OP_SW;
        default: op = OP_ILLEGAL;
      endcase
      fmt   = IMM_S;
      rs1_u = 1'b1;
      rs2_u = 1'b1;
    end
    7'h13: begin
      fmt   = IMM_I;
      rd_u  = 1'b1;
      rs1_u = 1'b1;
      case (f3)
        3'd0: op = OP_ADDI;
        3'd2: op = OP_SLTI;
        3'd3: op = OP_SLTIU;
        3'd4: op = OP_XORI;
        3'd6: op = OP_ORI;
        3'd7: op = OP_ANDI;
        3'd1: op = (f7 == 7'h00) ? OP_SLLI : OP_ILLEGAL;
        default: op = (f7 == 7'h00) ? OP_SRLI : (f7 == 7'h20) ? OP_SRAI : OP_ILLEGAL;
      endcase
      // shifts carry a shamt instead of a full immediate
      if (f3 == 3'd1 || f3 == 3'd5) fmt = IMM_SH;
    end
    7'h33: begin
      case ({f7, f3})
        {7'h00, 3'd0}: op = OP_ADD;
        {7'h20, 3'd0}: op = OP_SUB;
        {7'h00, 3'd1}: op = OP_SLL;
        {7'h00, 3'd2}: op = OP_SLT;
        {7'h00, 3'd3}: op = OP_SLTU;
        {7'h00, 3'd4}: op = OP_XOR;
        {7'h00, 3'd5}: op = OP_SRL;
        {7'h20, 3'd5}: op = OP_SRA;
        {7'h00, 3'd6}: op = OP_OR;
        {7'h00, 3'd7}: op = OP_AND;
        default: op = OP_ILLEGAL;
      endcase
      rd_u  = 1'b1;
      rs1_u = 1'b1;
      rs2_u = 1'b1;
    end
    7'h0f: if (f3 == 3'd0) op = OP_FENCE;
    7'h73: begin
      if (w == 32'h0000_0073) op = OP_ECALL;
      if (w == 32'h0010_0073) op = OP_EBREAK;
    end
    default: op = OP_ILLEGAL;
  endcase
  case (fmt)
    IMM_I:   imm = {{20{w[31]}}, w[31:20]};
    IMM_S:   imm = {{20{w[31]}}, w[31:25], w[11:7]};
    IMM_B:   imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    IMM_U:   imm = {w[31:12], 12'd0};
    IMM_J:   imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    IMM_SH:  imm = {27'd0, w[24:20]};
    default: imm = 32'd0;
  endcase
  ctrl = {4'd0, fmt, rs2_u, rs1_u, rd_u, rs2_u ? w[24:20] : 5'd0,
          rs1_u ? w[19:15] : 5'd0, rd_u ? w[11:7] : 5'd0, op};
  if (op == OP_ILLEGAL) begin
    ctrl = 32'h8000_0000;
    imm  = 32'd0;
  end
endfunction

// random fields with the encoding bits of op laid on top
function automatic logic [31:0] make_word(input rv_op_e op, input logic [31:0] rnd);
  logic [31:0] w;
  int          i;
  w = rnd;
  if (op <= OP_JAL) begin
    w[6:0] = (op == OP_LUI) ? 7'h37 : (op == OP_AUIPC) ? 7'h17 : 7'h6f;
  end else if (op == OP_JALR) begin
    w[14:0] = {3'd0, w[11:7], 7'h67};
  end else if (op <= OP_BGEU) begin
    i = op - OP_BEQ;
    w[14:12] = 3'(i < 2 ? i : i + 2);
    w[6:0]   = 7'h63;
  end else if (op <= OP_LHU) begin
    i = op - OP_LB;
    w[14:12] = 3'(i < 3 ? i : i + 1);
    w[6:0]   = 7'h03;
  end else if (op <= OP_SW) begin
    w[14:12] = 3'(op - OP_SB);
    w[6:0]   = 7'h23;
  end else if (op <= OP_ANDI) begin
    i = op - OP_ADDI;
    w[14:12] = 3'(i == 0 ? 0 : i < 4 ? i + 1 : i + 2);
    w[6:0]   = 7'h13;
  end else if (op <= OP_SRAI) begin
    w[31:25] = (op == OP_SRAI) ? 7'h20 : 7'h00;
    w[14:12] = (op == OP_SLLI) ? 3'd1 : 3'd5;
    w[6:0]   = 7'h13;
  end else if (op <= OP_AND) begin
    i = op - OP_ADD;
    w[31:25] = (op == OP_SUB || op == OP_SRA) ? 7'h20 : 7'h00;
    w[14:12] = 3'(i < 2 ? 0 : i < 7 ? i - 1 : i == 7 ? 5 : i - 2);
    w[6:0]   = 7'h33;
  end else if (op == OP_FENCE) begin
    w[14:12] = 3'd0;
    w[6:0]   = 7'h0f;
  end else begin
    w = (op == OP_ECALL) ? 32'h0000_0073 : 32'h0010_0073;
  end
  return w;
endfunction

// a legal word of a random operation, or a raw random word one time in eight
function automatic logic [31:0] pick_word();
  logic [31:0] sel;
  sel = rand_word();
  if (sel[31:29] == 3'd0) return rand_word();
  return make_word(rv_op_e'(6'(1 + sel[23:8] % 40)), rand_word());
endfunction

`endif

// ==== bench/tb_rv_decode_unit.sv ====
/*
  Testbench for the four-lane RV32I decode unit.
  Bus inputs change 10 ns after the rising edge; acks and read data are
  sampled on the falling edge. Stops at the first mismatch.
*/

`timescale 1ns/1ps

`include "rv_dec_config.svh"

module tb_rv_decode_unit
  import rv_dec_pkg::*;
();

  localparam int LANES       = `RV_DEC_LANES;
  localparam int CYCLE_LIMIT = 400 * 40;
  localparam logic [31:0] ALL_DONE = 32'((1 << LANES) - 1);

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`RV_DEC_ADR_W-1:0] wb_adr_i;
  logic [31:0]              wb_dat_i;
  logic [31:0]              wb_dat_o;
  logic                     wb_ack_o;

  logic [31:0] lcg_state = 32'h07137e03;
  logic [31:0] words [LANES];
  logic [31:0] exp_ctrl [LANES];
  logic [31:0] exp_imm [LANES];
  logic [40:0] seen = '0;
  int unsigned cycle_cnt = 0;
  // every format once, I and B twice
  rv_op_e fmt_ops [8] = '{OP_ADDI, OP_SW, OP_BNE, OP_LUI, OP_JAL, OP_SRAI, OP_LW, OP_BGEU};

  rv_decode_unit DUT (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "rv_dec_model.svh"

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus access
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  task automatic wb_write(input int adr, input logic [31:0] dat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = 4'(adr);
    wb_dat_i = dat;
    do @(negedge clk_i); while (!wb_ack_o);
    @(posedge clk_i);
    #10;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input int adr, output logic [31:0] dat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = 4'(adr);
    do @(negedge clk_i); while (!wb_ack_o);
    dat = wb_dat_o;
    @(posedge clk_i);
    #10;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s read %08h, expected %08h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic read_check(input int adr, input logic [31:0] exp, input string what);
    logic [31:0] got;
    wb_read(adr, got);
    check(got, exp, what);
  endtask

  task automatic read_results();
    for (int k = 0; k < LANES; k++) begin
      read_check(2 * k, exp_ctrl[k], $sformatf("lane %0d control word", k));
      read_check(2 * k + 1, exp_imm[k], $sformatf("lane %0d immediate", k));
    end
  endtask

  // one word per lane, then read every lane back
  task automatic run_round();
    for (int k = 0; k < LANES; k++) begin
      wb_write(k, words[k]);
      expected_decode(words[k], exp_ctrl[k], exp_imm[k]);
      seen[exp_ctrl[k][5:0]] = 1'b1;
    end
    idle(2);
    read_results();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          rounds;
    logic [31:0] w;
    logic [31:0] c;
    logic [31:0] i;
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    idle(10);
    rst_n_i = 1'b1;

    read_check(`RV_DEC_STATUS_ADR, 32'd0, "status after reset");
    for (int a = 0; a < 2 * LANES; a++) begin
      read_check(a, 32'd0, $sformatf("word %0d after reset", a));
    end

    // random rounds until all 40 operations have gone through
    rounds = 0;
    while (seen[40:1] != '1 || rounds < 16) begin
      for (int k = 0; k < LANES; k++) words[k] = pick_word();
      run_round();
      rounds++;
    end

    // sign bit one, then zero
    for (int s = 0; s < 2; s++) begin
      for (int g = 0; g < 8 / LANES; g++) begin
        for (int k = 0; k < LANES; k++) begin
          w = rand_word();
          w[31] = (s == 0);
          words[k] = make_word(fmt_ops[g * LANES + k], w);
        end
        run_round();
      end
    end

    repeat (2) begin
      for (int k = 0; k < LANES; k++) begin
        do begin
          words[k] = rand_word();
          expected_decode(words[k], c, i);
        end while (c != 32'h8000_0000 || i != 32'd0);
      end
      run_round();
    end

    // status clears on a write and comes back once the lane is done
    for (int k = 0; k < LANES; k++) begin
      wb_write(k, words[k]);
      read_check(`RV_DEC_STATUS_ADR, ALL_DONE & ~32'(1 << k), "status right after write");
      idle(2);
      read_check(`RV_DEC_STATUS_ADR, ALL_DONE, "status after decode");
    end

    for (int a = LANES; a < 16; a++) wb_write(a, rand_word());
    idle(2);
    read_results();
    read_check(`RV_DEC_STATUS_ADR, ALL_DONE, "status after unmapped writes");
    for (int a = 2 * LANES; a < `RV_DEC_STATUS_ADR; a++) begin
      read_check(a, 32'd0, $sformatf("unmapped address %0d", a));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hw
+incdir+bench
hw/rv_dec_pkg.sv
hw/rv_instr_latch.sv
hw/rv_decode_lane.sv
hw/rv_result_bank.sv
hw/rv_decode_unit.sv
bench/tb_rv_decode_unit.sv

// ==== Bender.yml ====
package:
  name: rv_decode_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_dec_pkg.sv
      - hw/rv_instr_latch.sv
      - hw/rv_decode_lane.sv
      - hw/rv_result_bank.sv
      - hw/rv_decode_unit.sv
  - target: test
    include_dirs:
      - hw
      - bench
    files:
      - bench/tb_rv_decode_unit.sv
